// File: logic/ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Data path width, one RV32 word
`define XLEN 32

// Multiplier latency in cycles, counted from the issue edge
// Two or more, since the pipeline shift line is at least two deep
`define MULT_STAGES 4

`endif

// File: logic/rv_isa_pkg.sv
`include "ex_settings.svh"

package rv_isa_pkg;

    // Base instruction word in R-type layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_inst_t;

    // Branch conditions, straight from funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_cond_e;

    ////////////////////////////////////////////////////////////////////////////
    // Sign-extended immediates

    function automatic logic [`XLEN-1:0] imm_i(rv_inst_t inst);
        logic [31:0] w;
        w = inst;
        return `XLEN'($signed(w[31:20]));
    endfunction

    function automatic logic [`XLEN-1:0] imm_s(rv_inst_t inst);
        logic [31:0] w;
        w = inst;
        return `XLEN'($signed({w[31:25], w[11:7]}));
    endfunction

    function automatic logic [`XLEN-1:0] imm_b(rv_inst_t inst);
        logic [31:0] w;
        w = inst;
        return `XLEN'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0})); // Halfword aligned
    endfunction

    function automatic logic [`XLEN-1:0] imm_u(rv_inst_t inst);
        logic [31:0] w;
        w = inst;
        return `XLEN'($signed({w[31:12], 12'b0}));
    endfunction

    function automatic logic [`XLEN-1:0] imm_j(rv_inst_t inst);
        logic [31:0] w;
        w = inst;
        return `XLEN'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
    endfunction

endpackage

// File: logic/ex_types_pkg.sv
`include "ex_settings.svh"

package ex_types_pkg;

    // ALU and multiplier opcodes
    typedef enum logic [3:0] {
        ALU_ADD    = 4'h0,
        ALU_SUB    = 4'h1,
        ALU_AND    = 4'h2,
        ALU_OR     = 4'h3,
        ALU_XOR    = 4'h4,
        ALU_SLT    = 4'h5,
        ALU_SLTU   = 4'h6,
        ALU_SLL    = 4'h7,
        ALU_SRL    = 4'h8,
        ALU_SRA    = 4'h9,
        ALU_MUL    = 4'ha,
        ALU_MULH   = 4'hb,
        ALU_MULHSU = 4'hc,
        ALU_MULHU  = 4'hd
    } alu_func_e;

    typedef enum logic {
        FU_INT,
        FU_MULT
    } funit_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_NPC,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2,
        OPB_IS_I_IMM,
        OPB_IS_S_IMM,
        OPB_IS_B_IMM,
        OPB_IS_U_IMM,
        OPB_IS_J_IMM
    } opb_sel_e;

    ////////////////////////////////////////////////////////////////////////////
    // Stage packets

    typedef struct packed {
        logic                 valid;
        funit_e               funit;
        alu_func_e            alu_func;
        opa_sel_e             opa_sel;
        opb_sel_e             opb_sel;
        logic [`XLEN-1:0]     pc;
        logic [`XLEN-1:0]     npc;
        logic [`XLEN-1:0]     rs1_value;
        logic [`XLEN-1:0]     rs2_value;
        rv_isa_pkg::rv_inst_t inst;
        logic                 cond_branch;
        logic                 uncond_branch;
        logic [4:0]           dest_reg;
        logic                 rd_mem;
        logic                 wr_mem;
        logic                 halt;
    } id_ex_packet_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] result;
        logic             take_branch;
        logic [`XLEN-1:0] npc;
        logic [`XLEN-1:0] rs2_value;   // Store data for the memory stage
        logic [4:0]       dest_reg;
        logic             rd_mem;
        logic             wr_mem;
        logic             mem_unsigned;
        logic [1:0]       mem_size;
        logic             halt;
    } ex_result_t;

endpackage

// File: logic/ex_operand_select.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_operand_select (
    input  ex_types_pkg::id_ex_packet_t issue_pkt,
    output logic [`XLEN-1:0]            opa,
    output logic [`XLEN-1:0]            opb
);
    import ex_types_pkg::*;
    import rv_isa_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // A operand

    always_comb begin
        case (issue_pkt.opa_sel)
            OPA_IS_RS1:  opa = issue_pkt.rs1_value;
            OPA_IS_NPC:  opa = issue_pkt.npc;      // Link address for jumps
            OPA_IS_PC:   opa = issue_pkt.pc;       // Branch and AUIPC base
            OPA_IS_ZERO: opa = '0;                 // LUI
            default:     opa = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // B operand

    // Immediates are decoded from the raw word on every cycle
    always_comb begin
        case (issue_pkt.opb_sel)
            OPB_IS_RS2: begin
                opb = issue_pkt.rs2_value;
            end
            OPB_IS_I_IMM: begin
                opb = imm_i(issue_pkt.inst);
            end
            OPB_IS_S_IMM: begin
                opb = imm_s(issue_pkt.inst);     // Store offset
            end
            OPB_IS_B_IMM: begin
                opb = imm_b(issue_pkt.inst);     // Branch offset
            end
            OPB_IS_U_IMM: begin
                opb = imm_u(issue_pkt.inst);
            end
            OPB_IS_J_IMM: begin
                opb = imm_j(issue_pkt.inst);     // JAL offset
            end
            default: begin
                opb = '0;
            end
        endcase
    end

endmodule

// File: logic/ex_int_unit.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_int_unit (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     int_en,
    input  logic [`XLEN-1:0]         opa,
    input  logic [`XLEN-1:0]         opb,
    input  ex_types_pkg::alu_func_e  alu_func,
    input  logic [`XLEN-1:0]         rs1_value,
    input  logic [`XLEN-1:0]         rs2_value,
    input  rv_isa_pkg::branch_cond_e branch_cond,
    output logic [`XLEN-1:0]         int_result,
    output logic                     take_cond
);
    import ex_types_pkg::*;
    import rv_isa_pkg::*;

    logic signed [`XLEN-1:0] opa_s;
    logic signed [`XLEN-1:0] opb_s;
    logic signed [`XLEN-1:0] rs1_s;
    logic signed [`XLEN-1:0] rs2_s;
    logic [4:0]              shamt;
    logic [`XLEN-1:0]        alu_next;
    logic                    cond_next;

    assign opa_s = opa;
    assign opb_s = opb;
    assign rs1_s = rs1_value;
    assign rs2_s = rs2_value;
    assign shamt = opb[4:0];   // RV32 shifts ignore the upper bits

    always_comb begin
        case (alu_func)
            ALU_ADD:  alu_next = opa + opb;     // Also the branch target
            ALU_SUB:  alu_next = opa - opb;
            ALU_AND:  alu_next = opa & opb;
            ALU_OR:   alu_next = opa | opb;
            ALU_XOR:  alu_next = opa ^ opb;
            ALU_SLT:  alu_next = `XLEN'(opa_s < opb_s);
            ALU_SLTU: alu_next = `XLEN'(opa < opb);
            ALU_SLL:  alu_next = opa << shamt;
            ALU_SRL:  alu_next = opa >> shamt;
            ALU_SRA:  alu_next = opa_s >>> shamt;
            default:  alu_next = '0;            // Multiplies belong to the other unit
        endcase
    end

    // Branch compare works on the raw register values, not the operands
    always_comb begin
        case (branch_cond)
            BR_EQ:   cond_next = (rs1_value == rs2_value);
            BR_NE:   cond_next = (rs1_value != rs2_value);
            BR_LT:   cond_next = (rs1_s < rs2_s);
            BR_GE:   cond_next = (rs1_s >= rs2_s);
            BR_LTU:  cond_next = (rs1_value < rs2_value);
            BR_GEU:  cond_next = (rs1_value >= rs2_value);
            default: cond_next = 1'b0;
        endcase
    end

    // Single result register, held between issues
    always_ff @(posedge clock) begin
        if (reset) begin
            int_result <= '0;
            take_cond  <= 1'b0;
        end else if (int_en) begin
            int_result <= alu_next;
            take_cond  <= cond_next;
        end
    end

endmodule

// File: logic/ex_multiplier.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_multiplier (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    mult_en,
    input  logic [`XLEN-1:0]        opa,
    input  logic [`XLEN-1:0]        opb,
    input  ex_types_pkg::alu_func_e alu_func,
    output logic [`XLEN-1:0]        product,
    output logic                    product_valid
);
    import ex_types_pkg::*;

    localparam int PROD_W  = 2 * `XLEN;
    // Multiplier bits per stage
    localparam int CHUNK_W = (PROD_W + `MULT_STAGES - 1) / `MULT_STAGES;

    typedef struct packed {
        logic              is_mul;
        logic              high;     // Return the upper word
        logic [PROD_W-1:0] mcand;
        logic [PROD_W-1:0] mplier;
        logic [PROD_W-1:0] acc;
    } mult_stage_t;

    logic                    signed_a;
    logic                    signed_b;
    logic                    is_mul;
    logic                    high;
    logic [`XLEN:0]          opa_ext;
    logic [`XLEN:0]          opb_ext;
    mult_stage_t             stage_in [`MULT_STAGES];
    mult_stage_t             stage_q  [`MULT_STAGES];
    mult_stage_t             last;
    logic [`MULT_STAGES-1:0] valid_q;

    // One chunk of partial products per stage, then move on to the next chunk
    function automatic mult_stage_t mult_step(mult_stage_t s);
        mult_stage_t       n;
        logic [PROD_W-1:0] chunk;
        n        = s;
        chunk    = PROD_W'(s.mplier[CHUNK_W-1:0]);
        n.acc    = s.acc + s.mcand * chunk;
        n.mcand  = s.mcand << CHUNK_W;
        n.mplier = s.mplier >> CHUNK_W;
        return n;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Opcode decode and operand extension

    always_comb begin
        signed_a = 1'b0;
        signed_b = 1'b0;
        is_mul   = 1'b1;
        high     = 1'b1;
        case (alu_func)
            ALU_MUL: begin
                signed_a = 1'b1;
                signed_b = 1'b1;
                high     = 1'b0;
            end
            ALU_MULH: begin
                signed_a = 1'b1;
                signed_b = 1'b1;
            end
            ALU_MULHSU: signed_a = 1'b1;
            ALU_MULHU:  high = 1'b1;
            default: begin
                is_mul = 1'b0;          // Not a multiply, product reads zero
                high   = 1'b0;
            end
        endcase
    end

    assign opa_ext = {signed_a & opa[`XLEN-1], opa};
    assign opb_ext = {signed_b & opb[`XLEN-1], opb};

    // Full-width sign extension keeps the low 64 bits of the product exact
    always_comb begin
        stage_in[0].is_mul = is_mul;
        stage_in[0].high   = high;
        stage_in[0].mcand  = PROD_W'($signed(opa_ext));
        stage_in[0].mplier = PROD_W'($signed(opb_ext));
        stage_in[0].acc    = '0;
        for (int i = 1; i < `MULT_STAGES; i++) begin
            stage_in[i] = stage_q[i-1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline registers

    always_ff @(posedge clock) begin
        for (int i = 0; i < `MULT_STAGES; i++) begin
            stage_q[i] <= mult_step(stage_in[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[`MULT_STAGES-2:0], mult_en};
        end
    end

    assign last = stage_q[`MULT_STAGES-1];

    always_comb begin
        if (!last.is_mul) begin
            product = '0;
        end else if (last.high) begin
            product = last.acc[PROD_W-1:`XLEN];
        end else begin
            product = last.acc[`XLEN-1:0];
        end
    end

    assign product_valid = valid_q[`MULT_STAGES-1];

endmodule

// File: logic/ex_control.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_control (
    input  logic                        clock,
    input  logic                        reset,
    input  ex_types_pkg::id_ex_packet_t issue_pkt,
    output logic                        int_en,
    output logic                        mult_en,
    input  logic [`XLEN-1:0]            int_result,
    input  logic                        take_cond,
    input  logic [`XLEN-1:0]            product,
    input  logic                        product_valid,
    output ex_types_pkg::ex_result_t    int_out,
    output ex_types_pkg::ex_result_t    mult_out
);
    import ex_types_pkg::*;

    id_ex_packet_t int_meta_q;
    logic          int_valid_q;
    id_ex_packet_t mult_meta_q [`MULT_STAGES];   // Tracks the multiplier pipeline

    // Joins unit data with the packet it was issued from
    function automatic ex_result_t make_result(
        input logic             valid,
        input logic [`XLEN-1:0] data,
        input logic             cond_true,
        input id_ex_packet_t    meta
    );
        ex_result_t r;
        r.valid        = valid;
        r.result       = data;
        r.take_branch  = meta.uncond_branch | (meta.cond_branch & cond_true);
        r.npc          = meta.npc;
        r.rs2_value    = meta.rs2_value;
        r.dest_reg     = meta.dest_reg;
        r.rd_mem       = meta.rd_mem;
        r.wr_mem       = meta.wr_mem;
        r.mem_unsigned = meta.inst.funct3[2];     // LBU and LHU
        r.mem_size     = meta.inst.funct3[1:0];   // Byte, half or word
        r.halt         = meta.halt;
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Issue steering

    assign int_en  = issue_pkt.valid && (issue_pkt.funit == FU_INT);
    assign mult_en = issue_pkt.valid && (issue_pkt.funit == FU_MULT);

    always_ff @(posedge clock) begin
        if (reset) begin
            int_valid_q <= 1'b0;
        end else begin
            int_valid_q <= int_en;   // One pulse per integer issue
        end
    end

    // Metadata follows its unit, the multiply line moves every cycle
    always_ff @(posedge clock) begin
        if (int_en) begin
            int_meta_q <= issue_pkt;
        end
        mult_meta_q[0] <= issue_pkt;
        for (int i = 1; i < `MULT_STAGES; i++) begin
            mult_meta_q[i] <= mult_meta_q[i-1];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result packets

    assign int_out = make_result(int_valid_q, int_result, take_cond, int_meta_q);

    // A multiply never evaluates a branch condition
    assign mult_out = make_result(product_valid, product, 1'b0,
                                  mult_meta_q[`MULT_STAGES-1]);

endmodule

// File: logic/ex_stage.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_stage (
    input  logic                        clock,
    input  logic                        reset,
    input  ex_types_pkg::id_ex_packet_t issue_pkt,
    output ex_types_pkg::ex_result_t    int_out,
    output ex_types_pkg::ex_result_t    mult_out
);
    import rv_isa_pkg::*;

    logic [`XLEN-1:0] opa;
    logic [`XLEN-1:0] opb;
    logic             int_en;
    logic             mult_en;
    logic [`XLEN-1:0] int_result;
    logic             take_cond;
    logic [`XLEN-1:0] product;
    logic             product_valid;

    ex_operand_select operand_select_i (
        .issue_pkt (issue_pkt),
        .opa       (opa),
        .opb       (opb)
    );

    ex_control control_i (
        .clock         (clock),
        .reset         (reset),
        .issue_pkt     (issue_pkt),
        .int_en        (int_en),
        .mult_en       (mult_en),
        .int_result    (int_result),
        .take_cond     (take_cond),
        .product       (product),
        .product_valid (product_valid),
        .int_out       (int_out),
        .mult_out      (mult_out)
    );

    ex_int_unit int_unit_i (
        .clock       (clock),
        .reset       (reset),
        .int_en      (int_en),
        .opa         (opa),
        .opb         (opb),
        .alu_func    (issue_pkt.alu_func),
        .rs1_value   (issue_pkt.rs1_value),
        .rs2_value   (issue_pkt.rs2_value),
        .branch_cond (branch_cond_e'(issue_pkt.inst.funct3)),   // Branch funct3
        .int_result  (int_result),
        .take_cond   (take_cond)
    );

    ex_multiplier multiplier_i (
        .clock         (clock),
        .reset         (reset),
        .mult_en       (mult_en),
        .opa           (opa),
        .opb           (opb),
        .alu_func      (issue_pkt.alu_func),
        .product       (product),
        .product_valid (product_valid)
    );

endmodule

// File: dv/ex_stage_assertions.sv
`timescale 1ns/10ps

module ex_stage_assertions (
    input logic                     clock,
    input logic                     reset,
    input logic                     int_en,
    input logic                     mult_en,
    input ex_types_pkg::ex_result_t int_out,
    input ex_types_pkg::ex_result_t mult_out
);
    int unsigned fail_count = 0;   // Read by the testbench at the end

    // Both result strobes low on the cycle after a reset edge
    reset_idle: assert property (@(posedge clock) reset |=> !int_out.valid && !mult_out.valid)
        else begin
            $error("Result valid seen during reset");
            fail_count++;
        end

    int_pulse: assert property (@(posedge clock) disable iff (reset)
                                int_en |=> int_out.valid)
        else begin
            $error("Integer issue without a result one cycle later");
            fail_count++;
        end

    // One packet goes to one unit
    one_unit: assert property (@(posedge clock) !(int_en && mult_en))
        else begin
            $error("Integer and multiply issue in the same cycle");
            fail_count++;
        end

endmodule

bind ex_control ex_stage_assertions assertions_i (
    .clock    (clock),
    .reset    (reset),
    .int_en   (int_en),
    .mult_en  (mult_en),
    .int_out  (int_out),
    .mult_out (mult_out)
);

// File: dv/ex_stage_tb.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_stage_tb;
    import ex_types_pkg::*;
    import rv_isa_pkg::*;

    localparam int RAND_OPS    = 64;
    localparam int DRAIN_LIMIT = 4 * `MULT_STAGES + 8;   // Idle cycles allowed to empty the pipes

    logic          clock;
    logic          reset;
    id_ex_packet_t issue_pkt;
    ex_result_t    int_out;
    ex_result_t    mult_out;

    ex_result_t    int_exp;                   // Due at the next falling edge
    ex_result_t    mult_exp [`MULT_STAGES];   // Index 0 is the newest issue

    ex_stage dut_i (
        .clock     (clock),
        .reset     (reset),
        .issue_pkt (issue_pkt),
        .int_out   (int_out),
        .mult_out  (mult_out)
    );

    always #20 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Checking

    task automatic stop_run();
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic compare_fields(input string port, input ex_result_t exp,
                                  input ex_result_t act);
        report_value({port, ".result"}, exp.result, act.result);
        report_value({port, ".take_branch"}, 32'(exp.take_branch), 32'(act.take_branch));
        report_value({port, ".npc"}, exp.npc, act.npc);
        report_value({port, ".rs2_value"}, exp.rs2_value, act.rs2_value);
        report_value({port, ".dest_reg"}, 32'(exp.dest_reg), 32'(act.dest_reg));
        report_value({port, ".rd_mem"}, 32'(exp.rd_mem), 32'(act.rd_mem));
        report_value({port, ".wr_mem"}, 32'(exp.wr_mem), 32'(act.wr_mem));
        report_value({port, ".mem_unsigned"}, 32'(exp.mem_unsigned), 32'(act.mem_unsigned));
        report_value({port, ".mem_size"}, 32'(exp.mem_size), 32'(act.mem_size));
        report_value({port, ".halt"}, 32'(exp.halt), 32'(act.halt));
    endtask

    task automatic check_int_result(input ex_result_t exp, input ex_result_t act);
        report_value("int_out.valid", 32'(exp.valid), 32'(act.valid));
        if (exp.valid) begin
            compare_fields("int_out", exp, act);
        end
    endtask

    task automatic check_mult_result(input ex_result_t exp, input ex_result_t act);
        report_value("mult_out.valid", 32'(exp.valid), 32'(act.valid));
        if (exp.valid) begin
            compare_fields("mult_out", exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    // Pass-through fields come straight from the issued packet
    function automatic ex_result_t expect_from(input id_ex_packet_t pkt,
                                               input logic [31:0] data, input logic take);
        ex_result_t r;
        r.valid        = pkt.valid;
        r.result       = data;
        r.take_branch  = take;
        r.npc          = pkt.npc;
        r.rs2_value    = pkt.rs2_value;
        r.dest_reg     = pkt.dest_reg;
        r.rd_mem       = pkt.rd_mem;
        r.wr_mem       = pkt.wr_mem;
        r.mem_unsigned = pkt.inst.funct3[2];
        r.mem_size     = pkt.inst.funct3[1:0];
        r.halt         = pkt.halt;
        return r;
    endfunction

    // Full 64-bit product, then pick the word
    function automatic logic [31:0] mult_model(input alu_func_e func, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        ea = {32'b0, a};
        eb = {32'b0, b};
        if (func == ALU_MUL || func == ALU_MULH || func == ALU_MULHSU) begin
            ea = {{32{a[31]}}, a};
        end
        if (func == ALU_MUL || func == ALU_MULH) begin
            eb = {{32{b[31]}}, b};
        end
        p = ea * eb;
        return (func == ALU_MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic pending();
        logic busy;
        busy = int_exp.valid;
        foreach (mult_exp[i]) begin
            busy = busy | mult_exp[i].valid;
        end
        return busy;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    // Check what is due, then drive the next packet
    task automatic issue_cycle(input id_ex_packet_t pkt, input logic [31:0] data,
                               input logic take);
        ex_result_t next;
        @(negedge clock);
        check_int_result(int_exp, int_out);
        check_mult_result(mult_exp[`MULT_STAGES-1], mult_out);
        for (int i = `MULT_STAGES - 1; i > 0; i--) begin
            mult_exp[i] = mult_exp[i-1];
        end
        next              = expect_from(pkt, data, take);
        int_exp           = next;
        int_exp.valid     = pkt.valid && (pkt.funit == FU_INT);
        mult_exp[0]       = next;
        mult_exp[0].valid = pkt.valid && (pkt.funit == FU_MULT);
        issue_pkt         = pkt;
    endtask

    task automatic drain_pipes();
        int cycles;
        cycles = 0;
        while (pending() && cycles < DRAIN_LIMIT) begin
            issue_cycle('0, '0, 1'b0);
            cycles++;
        end
        if (pending()) begin
            $display("Results still missing after %0d idle cycles", cycles);
            stop_run();
        end
    endtask

    task automatic run_vectors();
        int            fd;
        int            n;
        int            count;
        string         line;
        logic [31:0]   col [17];
        id_ex_packet_t pkt;
        count = 0;
        fd    = $fopen("dv/ex_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file dv/ex_vectors.txt");
            stop_run();
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 4 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                            col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                            col[14], col[15], col[16]);
                if (n != 17) begin
                    $display("Vector line has %0d fields instead of 17: %s", n, line);
                    stop_run();
                end
                pkt               = '0;
                pkt.valid         = 1'b1;
                pkt.funit         = funit_e'(col[0][0]);
                pkt.alu_func      = alu_func_e'(col[1][3:0]);
                pkt.opa_sel       = opa_sel_e'(col[2][1:0]);
                pkt.opb_sel       = opb_sel_e'(col[3][2:0]);
                pkt.pc            = col[4];
                pkt.npc           = col[5];
                pkt.rs1_value     = col[6];
                pkt.rs2_value     = col[7];
                pkt.inst          = rv_inst_t'(col[8]);
                pkt.cond_branch   = col[9][0];
                pkt.uncond_branch = col[10][0];
                pkt.dest_reg      = col[11][4:0];
                pkt.rd_mem        = col[12][0];
                pkt.wr_mem        = col[13][0];
                pkt.halt          = col[14][0];
                issue_cycle(pkt, col[15], col[16][0]);
                count++;
            end
        end
        $fclose(fd);
        if (count == 0) begin
            $display("The vector file holds no vectors");
            stop_run();
        end
    endtask

    // Back-to-back multiplies with integer ops and idle slots mixed in
    task automatic run_random();
        id_ex_packet_t pkt;
        logic [31:0]   r;
        logic [31:0]   data;
        logic [2:0]    pick;
        for (int n = 0; n < RAND_OPS; n++) begin
            r                 = $urandom();
            pick              = r[2:0];
            pkt               = '0;
            pkt.valid         = (pick != 3'd7);
            pkt.funit         = (pick < 3'd4) ? FU_MULT : FU_INT;
            pkt.pc            = $urandom();
            pkt.npc           = pkt.pc + 32'd4;
            pkt.rs1_value     = $urandom();
            pkt.rs2_value     = $urandom();
            pkt.inst          = rv_inst_t'($urandom());
            pkt.dest_reg      = r[7:3];
            pkt.rd_mem        = r[8];
            pkt.wr_mem        = r[9];
            pkt.halt          = r[10];
            pkt.uncond_branch = r[11];
            case (pick)
                3'd0:    pkt.alu_func = ALU_MUL;
                3'd1:    pkt.alu_func = ALU_MULH;
                3'd2:    pkt.alu_func = ALU_MULHSU;
                3'd3:    pkt.alu_func = ALU_MULHU;
                3'd4:    pkt.alu_func = ALU_ADD;
                3'd5:    pkt.alu_func = ALU_XOR;
                default: pkt.alu_func = ALU_SUB;
            endcase
            case (pkt.alu_func)
                ALU_ADD: data = pkt.rs1_value + pkt.rs2_value;
                ALU_XOR: data = pkt.rs1_value ^ pkt.rs2_value;
                ALU_SUB: data = pkt.rs1_value - pkt.rs2_value;
                default: data = mult_model(pkt.alu_func, pkt.rs1_value, pkt.rs2_value);
            endcase
            issue_cycle(pkt, data, pkt.uncond_branch);   // No conditional branches here
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        clock     = 1'b0;
        reset     = 1'b1;
        issue_pkt = '0;
        int_exp   = '0;
        foreach (mult_exp[i]) begin
            mult_exp[i] = '0;
        end
        void'($urandom(32'h32d9));
        repeat (5) begin
            @(negedge clock);
            report_value("int_out.valid", 32'd0, 32'(int_out.valid));
            report_value("mult_out.valid", 32'd0, 32'(mult_out.valid));
        end
        reset = 1'b0;
        run_vectors();
        drain_pipes();
        run_random();
        drain_pipes();
        if (dut_i.control_i.assertions_i.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures in the bound checker",
                     dut_i.control_i.assertions_i.fail_count);
            stop_run();
        end
    end

endmodule

// File: dv/ex_vectors.txt
# funit func opa_sel opb_sel pc npc rs1 rs2 inst cond uncond dest rd_mem wr_mem halt
# then the expected result and expected take_branch, all fields in hex
# Integer ops on rs1 and rs2, shifts by 31 and by 0
0 0 0 0 00001000 00001004 7fffffff 00000001 00000033 0 0 01 0 0 0 80000000 0
0 1 0 0 00001004 00001008 00000000 00000001 40000033 0 0 02 0 0 0 ffffffff 0
0 2 0 0 00001008 0000100c f0f0f0f0 ff00ff00 00007033 0 0 03 1 0 0 f000f000 0
0 3 0 0 0000100c 00001010 f0f0f0f0 0f0f0000 00006033 0 0 04 0 0 0 fffff0f0 0
0 4 0 0 00001010 00001014 aaaaaaaa ffff0000 00004033 0 0 05 0 1 0 5555aaaa 0
0 5 0 0 00001014 00001018 ffffffff 00000001 00002033 0 0 06 0 0 0 00000001 0
0 6 0 0 00001018 0000101c ffffffff 00000001 00003033 0 0 07 0 0 0 00000000 0
0 7 0 0 0000101c 00001020 00000003 0000001f 00001033 0 0 08 0 0 0 80000000 0
0 7 0 0 00001020 00001024 12345678 00000020 00001033 0 0 09 0 0 0 12345678 0
0 8 0 0 00001024 00001028 80000000 0000001f 00005033 0 0 0a 0 0 0 00000001 0
0 8 0 0 00001028 0000102c 80000000 00000000 00005033 0 0 0b 0 0 0 80000000 0
0 9 0 0 0000102c 00001030 80000000 0000001f 40005033 0 0 0c 0 0 1 ffffffff 0
0 9 0 0 00001030 00001034 80000001 ffffffe0 40005033 0 0 1f 0 0 0 80000001 0
# Operand select with pc, npc and zero against the immediates
0 0 1 1 00002000 00002004 00000000 00000000 ffc04083 0 0 01 1 0 0 00002000 0
0 0 2 2 00003000 00003004 00000000 deadbeef fe002c23 0 0 00 0 1 0 00002ff8 0
0 0 2 4 00004000 00004004 00000000 00000000 12345017 0 0 02 0 0 0 12349000 0
0 0 3 4 00004004 00004008 00000000 00000000 fffff0b7 0 0 01 0 0 0 fffff000 0
# Branches, target is pc plus the B immediate
0 0 2 3 00005000 00005004 00000005 00000005 00000863 1 0 00 0 0 0 00005010 1
0 0 2 3 00005000 00005004 00000005 00000006 fe0008e3 1 0 00 0 0 0 00004ff0 0
0 0 2 3 00005000 00005004 00000005 00000006 00001863 1 0 00 0 0 0 00005010 1
0 0 2 3 00005000 00005004 00000005 00000005 fe0018e3 1 0 00 0 0 0 00004ff0 0
0 0 2 3 00005000 00005004 ffffffff 00000001 00004863 1 0 00 0 0 0 00005010 1
0 0 2 3 00005000 00005004 00000001 ffffffff fe0048e3 1 0 00 0 0 0 00004ff0 0
0 0 2 3 00005000 00005004 00000001 ffffffff 00005863 1 0 00 0 0 0 00005010 1
0 0 2 3 00005000 00005004 ffffffff 00000001 fe0058e3 1 0 00 0 0 0 00004ff0 0
0 0 2 3 00005000 00005004 00000001 ffffffff 00006863 1 0 00 0 0 0 00005010 1
0 0 2 3 00005000 00005004 ffffffff 00000001 fe0068e3 1 0 00 0 0 0 00004ff0 0
0 0 2 3 00005000 00005004 ffffffff 00000001 00007863 1 0 00 0 0 0 00005010 1
0 0 2 3 00005000 00005004 00000001 ffffffff fe0078e3 1 0 00 0 0 0 00004ff0 0
# Jump, target is pc plus the J immediate
0 0 2 5 00006000 00006004 00000000 00000000 001000ef 0 1 01 0 0 0 00006800 1
# Multiplies with extreme operands
1 a 0 0 00007000 00007004 80000000 ffffffff 02000033 0 0 0a 0 0 0 80000000 0
1 b 0 0 00007004 00007008 80000000 80000000 02001033 0 0 0b 0 0 0 40000000 0
1 c 0 0 00007008 0000700c 80000000 ffffffff 02002033 0 0 0c 0 0 0 80000000 0
1 d 0 0 0000700c 00007010 ffffffff ffffffff 02003033 0 0 0d 0 0 1 fffffffe 0

// File: flist.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/ex_types_pkg.sv
logic/ex_operand_select.sv
logic/ex_int_unit.sv
logic/ex_multiplier.sv
logic/ex_control.sv
logic/ex_stage.sv
dv/ex_stage_assertions.sv
dv/ex_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the execute-stage testbench with Verilator, run it, then judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f flist.f --top-module ex_stage_tb \
    -Mdir obj_dir -o ex_stage_sim \
    && ./obj_dir/ex_stage_sim > sim.log 2>&1 \
    || echo "Build or simulation exited with an error"

grep -q "^Simulation PASSED$" sim.log 2>/dev/null \
    && echo "Run passed, see sim.log" \
    || { echo "Run failed, see sim.log"; exit 1; }
